/* rtl/lsu_pkg.sv */
// Shared widths, queue sizes and encodings, imported by every load/store unit module
`default_nettype none

package lsu_pkg;

  // ----------------------------------------------------------------------
  // Datapath widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int TAG_W  = 4;
  localparam int SEL_W  = DATA_W / 8;

  // ----------------------------------------------------------------------
  // Queue sizes
  // ----------------------------------------------------------------------
  localparam int IQ_DEPTH = 4;
  localparam int RQ_DEPTH = 4;
  // ex0 and ex1 can both divert in the same window
  localparam int RQ_RESERVE = 2;

  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
  localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);
  localparam int RQ_PTR_W = $clog2(RQ_DEPTH);
  localparam int RQ_CNT_W = $clog2(RQ_DEPTH + 1);

  // Memory operations
  typedef enum logic [1:0] {
    OP_LW,
    OP_SW,
    OP_LBU,
    OP_SB
  } lsu_op_e;

  // What ex1 does with its operation
  typedef enum logic [1:0] {
    OUT_ACCESS,
    OUT_REPLAY,
    OUT_EXCEPT
  } lsu_outcome_e;

  function automatic logic is_store(lsu_op_e op);
    return (op == OP_SW) || (op == OP_SB);
  endfunction

  function automatic logic is_word(lsu_op_e op);
    return (op == OP_LW) || (op == OP_SW);
  endfunction

endpackage

`default_nettype wire

/* rtl/lsu_issue_queue.sv */
// In-order queue for dispatched memory operations; assigns tags and holds its head while stalled
`timescale 1ns/10ps
`default_nettype none

module lsu_issue_queue (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_disp_valid,
  input  lsu_pkg::lsu_op_e           i_disp_op,
  input  logic [lsu_pkg::ADDR_W-1:0] i_disp_addr,
  input  logic [lsu_pkg::DATA_W-1:0] i_disp_data,
  output logic                       o_disp_ready,
  input  logic                       i_stall,
  output logic                       o_valid,
  output lsu_pkg::lsu_op_e           o_op,
  output logic [lsu_pkg::ADDR_W-1:0] o_addr,
  output logic [lsu_pkg::DATA_W-1:0] o_data,
  output logic [lsu_pkg::TAG_W-1:0]  o_tag
);
  import lsu_pkg::*;

  lsu_op_e             r_op   [IQ_DEPTH];
  logic [ADDR_W-1:0]   r_addr [IQ_DEPTH];
  logic [DATA_W-1:0]   r_data [IQ_DEPTH];
  logic [TAG_W-1:0]    r_tag  [IQ_DEPTH];
  logic [IQ_PTR_W-1:0] r_wr_ptr;
  logic [IQ_PTR_W-1:0] r_rd_ptr;
  logic [IQ_CNT_W-1:0] r_count;
  logic [TAG_W-1:0]    r_next_tag;
  logic                w_push;
  logic                w_pop;

  assign o_disp_ready = (r_count != IQ_CNT_W'(IQ_DEPTH));
  assign o_valid      = (r_count != '0);
  assign w_push       = i_disp_valid && o_disp_ready;
  assign w_pop        = o_valid && !i_stall;

  // Entry storage
  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_op[r_wr_ptr]   <= i_disp_op;
      r_addr[r_wr_ptr] <= i_disp_addr;
      r_data[r_wr_ptr] <= i_disp_data;
      r_tag[r_wr_ptr]  <= r_next_tag;
    end
  end

  // Pointers, occupancy and tag counter
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_wr_ptr   <= '0;
      r_rd_ptr   <= '0;
      r_count    <= '0;
      r_next_tag <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr   <= r_wr_ptr + 1'b1;
        r_next_tag <= r_next_tag + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // Head of queue
  assign o_op   = r_op[r_rd_ptr];
  assign o_addr = r_addr[r_rd_ptr];
  assign o_data = r_data[r_rd_ptr];
  assign o_tag  = r_tag[r_rd_ptr];

  // A full queue takes no new entry
  a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
    (r_count == IQ_CNT_W'(IQ_DEPTH)) |=> ($stable(r_wr_ptr) && $stable(r_next_tag)));

endmodule

`default_nettype wire

/* rtl/lsu_replay_queue.sv */
// FIFO of operations diverted by the pipe, re-issued ahead of the issue queue in arrival order
`timescale 1ns/10ps
`default_nettype none

module lsu_replay_queue (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_push,
  input  lsu_pkg::lsu_op_e           i_op,
  input  logic [lsu_pkg::ADDR_W-1:0] i_addr,
  input  logic [lsu_pkg::DATA_W-1:0] i_data,
  input  logic [lsu_pkg::TAG_W-1:0]  i_tag,
  output logic                       o_valid,
  output lsu_pkg::lsu_op_e           o_op,
  output logic [lsu_pkg::ADDR_W-1:0] o_addr,
  output logic [lsu_pkg::DATA_W-1:0] o_data,
  output logic [lsu_pkg::TAG_W-1:0]  o_tag,
  input  logic                       i_pop,
  output logic                       o_almost_full,
  output logic                       o_empty
);
  import lsu_pkg::*;

  lsu_op_e             r_op   [RQ_DEPTH];
  logic [ADDR_W-1:0]   r_addr [RQ_DEPTH];
  logic [DATA_W-1:0]   r_data [RQ_DEPTH];
  logic [TAG_W-1:0]    r_tag  [RQ_DEPTH];
  logic [RQ_PTR_W-1:0] r_wr_ptr;
  logic [RQ_PTR_W-1:0] r_rd_ptr;
  logic [RQ_CNT_W-1:0] r_count;
  logic [RQ_CNT_W-1:0] w_free;
  logic                w_pop;

  assign o_empty = (r_count == '0);
  assign o_valid = !o_empty;
  assign w_pop   = i_pop && o_valid;
  assign w_free  = RQ_CNT_W'(RQ_DEPTH) - r_count;

  // Keep room for whatever is still in ex0 and ex1
  assign o_almost_full = (w_free < RQ_CNT_W'(RQ_RESERVE));

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_op[r_wr_ptr]   <= i_op;
      r_addr[r_wr_ptr] <= i_addr;
      r_data[r_wr_ptr] <= i_data;
      r_tag[r_wr_ptr]  <= i_tag;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({i_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  assign o_op   = r_op[r_rd_ptr];
  assign o_addr = r_addr[r_rd_ptr];
  assign o_data = r_data[r_rd_ptr];
  assign o_tag  = r_tag[r_rd_ptr];

  // Pipe diversions must never find the queue full
  a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
    (r_count == RQ_CNT_W'(RQ_DEPTH)) |-> !i_push);

endmodule

`default_nettype wire

/* rtl/lsu_pipe.sv */
// Two-stage memory pipe: ex1 checks alignment, diverts to replay or runs a Wishbone access
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_valid,
  input  logic                       i_from_replay,
  input  lsu_pkg::lsu_op_e           i_op,
  input  logic [lsu_pkg::ADDR_W-1:0] i_addr,
  input  logic [lsu_pkg::DATA_W-1:0] i_data,
  input  logic [lsu_pkg::TAG_W-1:0]  i_tag,
  input  logic                       i_replay_empty,
  output logic                       o_replay_push,
  output lsu_pkg::lsu_op_e           o_replay_op,
  output logic [lsu_pkg::ADDR_W-1:0] o_replay_addr,
  output logic [lsu_pkg::DATA_W-1:0] o_replay_data,
  output logic [lsu_pkg::TAG_W-1:0]  o_replay_tag,
  output logic                       o_wb_cyc,
  output logic                       o_wb_stb,
  output logic                       o_wb_we,
  output logic [lsu_pkg::ADDR_W-1:0] o_wb_adr,
  output logic [lsu_pkg::DATA_W-1:0] o_wb_dat,
  output logic [lsu_pkg::SEL_W-1:0]  o_wb_sel,
  input  logic [lsu_pkg::DATA_W-1:0] i_wb_dat,
  input  logic                       i_wb_ack,
  output logic                       o_done_valid,
  output logic [lsu_pkg::TAG_W-1:0]  o_done_tag,
  output logic [lsu_pkg::DATA_W-1:0] o_done_data,
  output logic                       o_done_except
);
  import lsu_pkg::*;

  logic              r_ex0_valid;
  logic              r_ex0_from_replay;
  lsu_op_e           r_ex0_op;
  logic [ADDR_W-1:0] r_ex0_addr;
  logic [DATA_W-1:0] r_ex0_data;
  logic [TAG_W-1:0]  r_ex0_tag;
  logic              r_ex1_valid;
  logic              r_ex1_from_replay;
  lsu_op_e           r_ex1_op;
  logic [ADDR_W-1:0] r_ex1_addr;
  logic [DATA_W-1:0] r_ex1_data;
  logic [TAG_W-1:0]  r_ex1_tag;
  lsu_outcome_e      w_outcome;
  logic              w_misaligned;
  logic              w_hold_order;
  logic              w_in_window;
  logic [1:0]        r_window;
  logic              w_divert;
  logic              w_start;
  logic              w_fault;
  logic              w_ack;
  logic [1:0]        w_lane;
  logic [SEL_W-1:0]  w_sel;
  logic [DATA_W-1:0] w_wdata;
  logic [TAG_W-1:0]  r_acc_tag;
  lsu_op_e           r_acc_op;
  logic [1:0]        r_acc_lane;
  logic [7:0]        w_rd_byte;

  // ----------------------------------------------------------------------
  // ex0 and ex1 registers
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex0_valid <= i_valid;
      r_ex1_valid <= r_ex0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_from_replay <= i_from_replay;
    r_ex0_op          <= i_op;
    r_ex0_addr        <= i_addr;
    r_ex0_data        <= i_data;
    r_ex0_tag         <= i_tag;
    r_ex1_from_replay <= r_ex0_from_replay;
    r_ex1_op          <= r_ex0_op;
    r_ex1_addr        <= r_ex0_addr;
    r_ex1_data        <= r_ex0_data;
    r_ex1_tag         <= r_ex0_tag;
  end

  // ----------------------------------------------------------------------
  // ex1 decision
  // ----------------------------------------------------------------------
  assign w_misaligned = is_word(r_ex1_op) && (r_ex1_addr[1:0] != 2'b00);
  // Older diverted work is still waiting
  assign w_hold_order = !r_ex1_from_replay && !i_replay_empty;
  // The two operations behind a diversion follow it into replay
  assign w_in_window  = r_window[0];

  always_comb begin
    if (o_wb_cyc || w_in_window || w_hold_order) begin
      w_outcome = OUT_REPLAY;
    end else if (w_misaligned) begin
      w_outcome = OUT_EXCEPT;
    end else begin
      w_outcome = OUT_ACCESS;
    end
  end

  assign w_divert = r_ex1_valid && (w_outcome == OUT_REPLAY);
  assign w_start  = r_ex1_valid && (w_outcome == OUT_ACCESS);
  assign w_fault  = r_ex1_valid && (w_outcome == OUT_EXCEPT);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_window <= 2'b00;
    end else if (w_divert && !w_in_window) begin
      r_window <= 2'b11;
    end else begin
      r_window <= {1'b0, r_window[1]};
    end
  end

  // Entry lands in the replay queue on the next edge
  assign o_replay_push = w_divert;
  assign o_replay_op   = r_ex1_op;
  assign o_replay_addr = r_ex1_addr;
  assign o_replay_data = r_ex1_data;
  assign o_replay_tag  = r_ex1_tag;

  // ----------------------------------------------------------------------
  // Wishbone classic master
  // ----------------------------------------------------------------------
  assign w_lane  = r_ex1_addr[1:0];
  assign w_sel   = is_word(r_ex1_op) ? {SEL_W{1'b1}} : (SEL_W'(1) << w_lane);
  assign w_wdata = (r_ex1_op == OP_SB) ? {SEL_W{r_ex1_data[7:0]}} : r_ex1_data;
  assign w_ack   = o_wb_cyc && i_wb_ack;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_cyc <= 1'b0;
      o_wb_stb <= 1'b0;
    end else if (w_start) begin
      o_wb_cyc <= 1'b1;
      o_wb_stb <= 1'b1;
    end else if (w_ack) begin
      o_wb_cyc <= 1'b0;
      o_wb_stb <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      o_wb_we    <= is_store(r_ex1_op);
      o_wb_adr   <= {r_ex1_addr[ADDR_W-1:2], 2'b00};
      o_wb_sel   <= w_sel;
      o_wb_dat   <= w_wdata;
      r_acc_tag  <= r_ex1_tag;
      r_acc_op   <= r_ex1_op;
      r_acc_lane <= w_lane;
    end
  end

  // ----------------------------------------------------------------------
  // Done report
  // ----------------------------------------------------------------------
  assign w_rd_byte = i_wb_dat[{r_acc_lane, 3'b000} +: 8];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_done_valid <= 1'b0;
    end else begin
      o_done_valid <= w_ack || w_fault;
    end
  end

  // Ack and fault never coincide since a fault needs an idle bus
  always_ff @(posedge i_clk) begin
    if (w_ack) begin
      o_done_tag    <= r_acc_tag;
      o_done_except <= 1'b0;
      case (r_acc_op)
        OP_LW:   o_done_data <= i_wb_dat;
        OP_LBU:  o_done_data <= {{(DATA_W - 8){1'b0}}, w_rd_byte};
        default: o_done_data <= '0;
      endcase
    end else if (w_fault) begin
      o_done_tag    <= r_ex1_tag;
      o_done_except <= 1'b1;
      o_done_data   <= '0;
    end
  end

  a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
    o_wb_stb |-> o_wb_cyc);

  a_wb_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_we) && $stable(o_wb_adr)
                                 && $stable(o_wb_sel) && $stable(o_wb_dat)));

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
// Load/store unit top level; feeds the pipe from the replay queue first, then from the issue queue
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_disp_valid,
  input  lsu_pkg::lsu_op_e           i_disp_op,
  input  logic [lsu_pkg::ADDR_W-1:0] i_disp_addr,
  input  logic [lsu_pkg::DATA_W-1:0] i_disp_data,
  output logic                       o_disp_ready,
  output logic                       o_wb_cyc,
  output logic                       o_wb_stb,
  output logic                       o_wb_we,
  output logic [lsu_pkg::ADDR_W-1:0] o_wb_adr,
  output logic [lsu_pkg::DATA_W-1:0] o_wb_dat,
  output logic [lsu_pkg::SEL_W-1:0]  o_wb_sel,
  input  logic [lsu_pkg::DATA_W-1:0] i_wb_dat,
  input  logic                       i_wb_ack,
  output logic                       o_done_valid,
  output logic [lsu_pkg::TAG_W-1:0]  o_done_tag,
  output logic [lsu_pkg::DATA_W-1:0] o_done_data,
  output logic                       o_done_except
);
  import lsu_pkg::*;

  logic              w_iq_valid;
  lsu_op_e           w_iq_op;
  logic [ADDR_W-1:0] w_iq_addr;
  logic [DATA_W-1:0] w_iq_data;
  logic [TAG_W-1:0]  w_iq_tag;
  logic              w_iq_stall;
  logic              w_rq_valid;
  lsu_op_e           w_rq_op;
  logic [ADDR_W-1:0] w_rq_addr;
  logic [DATA_W-1:0] w_rq_data;
  logic [TAG_W-1:0]  w_rq_tag;
  logic              w_rq_almost_full;
  logic              w_rq_empty;
  logic              w_push;
  lsu_op_e           w_push_op;
  logic [ADDR_W-1:0] w_push_addr;
  logic [DATA_W-1:0] w_push_data;
  logic [TAG_W-1:0]  w_push_tag;
  logic              w_pick_valid;
  lsu_op_e           w_pick_op;
  logic [ADDR_W-1:0] w_pick_addr;
  logic [DATA_W-1:0] w_pick_data;
  logic [TAG_W-1:0]  w_pick_tag;

  lsu_issue_queue u_issue_queue (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_disp_valid (i_disp_valid),
    .i_disp_op    (i_disp_op),
    .i_disp_addr  (i_disp_addr),
    .i_disp_data  (i_disp_data),
    .o_disp_ready (o_disp_ready),
    .i_stall      (w_iq_stall),
    .o_valid      (w_iq_valid),
    .o_op         (w_iq_op),
    .o_addr       (w_iq_addr),
    .o_data       (w_iq_data),
    .o_tag        (w_iq_tag)
  );

  lsu_replay_queue u_replay_queue (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_push        (w_push),
    .i_op          (w_push_op),
    .i_addr        (w_push_addr),
    .i_data        (w_push_data),
    .i_tag         (w_push_tag),
    .o_valid       (w_rq_valid),
    .o_op          (w_rq_op),
    .o_addr        (w_rq_addr),
    .o_data        (w_rq_data),
    .o_tag         (w_rq_tag),
    .i_pop         (w_rq_valid),
    .o_almost_full (w_rq_almost_full),
    .o_empty       (w_rq_empty)
  );

  // ----------------------------------------------------------------------
  // Source selection, replay entries are always older
  // ----------------------------------------------------------------------
  assign w_iq_stall = w_rq_valid || w_rq_almost_full;

  always_comb begin
    if (w_rq_valid) begin
      w_pick_valid = 1'b1;
      w_pick_op    = w_rq_op;
      w_pick_addr  = w_rq_addr;
      w_pick_data  = w_rq_data;
      w_pick_tag   = w_rq_tag;
    end else begin
      w_pick_valid = w_iq_valid && !w_iq_stall;
      w_pick_op    = w_iq_op;
      w_pick_addr  = w_iq_addr;
      w_pick_data  = w_iq_data;
      w_pick_tag   = w_iq_tag;
    end
  end

  lsu_pipe u_lsu_pipe (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_valid        (w_pick_valid),
    .i_from_replay  (w_rq_valid),
    .i_op           (w_pick_op),
    .i_addr         (w_pick_addr),
    .i_data         (w_pick_data),
    .i_tag          (w_pick_tag),
    .i_replay_empty (w_rq_empty),
    .o_replay_push  (w_push),
    .o_replay_op    (w_push_op),
    .o_replay_addr  (w_push_addr),
    .o_replay_data  (w_push_data),
    .o_replay_tag   (w_push_tag),
    .o_wb_cyc       (o_wb_cyc),
    .o_wb_stb       (o_wb_stb),
    .o_wb_we        (o_wb_we),
    .o_wb_adr       (o_wb_adr),
    .o_wb_dat       (o_wb_dat),
    .o_wb_sel       (o_wb_sel),
    .i_wb_dat       (i_wb_dat),
    .i_wb_ack       (i_wb_ack),
    .o_done_valid   (o_done_valid),
    .o_done_tag     (o_done_tag),
    .o_done_data    (o_done_data),
    .o_done_except  (o_done_except)
  );

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
// Random-stimulus testbench for lsu_top with a Wishbone memory model and a program-order reference
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int N_TAGS     = 2 ** TAG_W;
  localparam int N_WORD     = 8;
  localparam int N_LANE     = 9;
  localparam int N_MISALIGN = 6;
  localparam int N_STRESS   = 200;
  localparam int N_OPS      = 2 * N_WORD + N_LANE + N_MISALIGN + N_STRESS;
  localparam int MAX_CYCLES = 40 * N_OPS + 100;

  logic              clk;
  logic              reset;
  logic              disp_valid;
  lsu_op_e           disp_op;
  logic [ADDR_W-1:0] disp_addr;
  logic [DATA_W-1:0] disp_data;
  logic              disp_ready;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [SEL_W-1:0]  wb_sel;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;
  logic              done_valid;
  logic [TAG_W-1:0]  done_tag;
  logic [DATA_W-1:0] done_data;
  logic              done_except;

  // Slave memory and the program-order model of it
  logic [DATA_W-1:0] mem     [MEM_WORDS];
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];

  // Expected result per tag, set when the operation is accepted
  logic [DATA_W-1:0] exp_data   [N_TAGS];
  bit                exp_except [N_TAGS];
  bit                pending    [N_TAGS];
  logic [TAG_W-1:0]  next_tag;

  integer seed        = 74517;
  int     cycles      = 0;
  int     n_checks    = 0;
  int     n_errors    = 0;
  int     n_sent      = 0;
  int     n_done      = 0;
  int     outstanding = 0;
  int     bus_starts  = 0;
  bit     slow_ack    = 1'b0;

  lsu_top i_dut (
    .i_clk         (clk),
    .i_reset       (reset),
    .i_disp_valid  (disp_valid),
    .i_disp_op     (disp_op),
    .i_disp_addr   (disp_addr),
    .i_disp_data   (disp_data),
    .o_disp_ready  (disp_ready),
    .o_wb_cyc      (wb_cyc),
    .o_wb_stb      (wb_stb),
    .o_wb_we       (wb_we),
    .o_wb_adr      (wb_adr),
    .o_wb_dat      (wb_dat_w),
    .o_wb_sel      (wb_sel),
    .i_wb_dat      (wb_dat_r),
    .i_wb_ack      (wb_ack),
    .o_done_valid  (done_valid),
    .o_done_tag    (done_tag),
    .o_done_data   (done_data),
    .o_done_except (done_except)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers and compare tasks
  // ----------------------------------------------------------------------
  function automatic int rand_below(int n);
    rand_below = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(int idx);
    fill_word = (idx + 1) * 32'h9e37_79b9;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_data(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_except(logic [TAG_W-1:0] tag, bit got, bit exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error o_done_except[tag 0x%0h] got 0x%0h expected 0x%0h", tag, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_tag_pending(logic [TAG_W-1:0] tag);
    n_checks++;
    if (!pending[tag]) begin
      n_errors++;
      $display("done report for tag %0d arrived with no operation pending on it", tag);
    end
  endtask

  task automatic end_test(string name, int errs_before);
    $display("%-24s %s (%0d errors)", name,
             (n_errors == errs_before) ? "ok" : "FAILED", n_errors - errs_before);
  endtask

  // ----------------------------------------------------------------------
  // Dispatch and reference model
  // ----------------------------------------------------------------------
  task automatic send_op(lsu_op_e op, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
    logic [7:0] widx;
    logic [4:0] bit_lo;
    bit         word_op;
    widx    = addr[9:2];
    bit_lo  = {addr[1:0], 3'b000};
    word_op = (op == OP_LW) || (op == OP_SW);
    // A tag is reused only once its earlier owner is done
    while (pending[next_tag]) begin
      step();
    end
    disp_valid = 1'b1;
    disp_op    = op;
    disp_addr  = addr;
    disp_data  = data;
    while (!disp_ready) begin
      step();
    end
    exp_except[next_tag] = word_op && (addr[1:0] != 2'b00);
    exp_data[next_tag]   = '0;
    if (!exp_except[next_tag]) begin
      case (op)
        OP_LW:   exp_data[next_tag] = ref_mem[widx];
        OP_SW:   ref_mem[widx] = data;
        OP_LBU:  exp_data[next_tag] = {24'h0, ref_mem[widx][bit_lo +: 8]};
        default: ref_mem[widx][bit_lo +: 8] = data[7:0];
      endcase
    end
    pending[next_tag] = 1'b1;
    outstanding++;
    n_sent++;
    next_tag = next_tag + 1'b1;
    step();
    disp_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (outstanding != 0) begin
      step();
    end
    repeat (2) step();
  endtask

  // ----------------------------------------------------------------------
  // Wishbone slave, 0 to 4 wait cycles per access
  // ----------------------------------------------------------------------
  initial begin : wb_slave
    int         wait_left;
    bit         busy;
    logic [7:0] widx;
    wait_left = 0;
    busy      = 1'b0;
    forever begin
      step();
      if (reset) begin
        wb_ack = 1'b0;
        busy   = 1'b0;
      end else if (wb_ack) begin
        wb_ack = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!busy) begin
          busy      = 1'b1;
          bus_starts++;
          wait_left = slow_ack ? 2 + rand_below(3) : rand_below(5);
        end
        if (wait_left == 0) begin
          widx = wb_adr[9:2];
          if (wb_we) begin
            for (int b = 0; b < SEL_W; b++) begin
              if (wb_sel[b]) begin
                mem[widx][b*8 +: 8] = wb_dat_w[b*8 +: 8];
              end
            end
          end
          wb_dat_r = mem[widx];
          wb_ack   = 1'b1;
          busy     = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  // Done reports are stable mid-cycle
  always @(negedge clk) begin
    if (!reset && done_valid) begin
      check_tag_pending(done_tag);
      if (pending[done_tag]) begin
        check_except(done_tag, done_except, exp_except[done_tag]);
        if (!exp_except[done_tag]) begin
          check_data($sformatf("o_done_data[tag 0x%0h]", done_tag), done_data,
                     exp_data[done_tag]);
        end
        pending[done_tag] = 1'b0;
        outstanding--;
      end
      n_done++;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d operations still waiting for done",
               cycles, outstanding);
      $display("test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int                errs;
    int                starts_before;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] base;
    logic [7:0]        mis_idx [N_MISALIGN];
    lsu_op_e           op;

    reset      = 1'b1;
    disp_valid = 1'b0;
    disp_op    = OP_LW;
    disp_addr  = '0;
    disp_data  = '0;
    wb_dat_r   = '0;
    wb_ack     = 1'b0;
    next_tag   = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int t = 0; t < N_TAGS; t++) begin
      pending[t] = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    errs = n_errors;
    check_flag("o_wb_cyc", wb_cyc, 1'b0);
    check_flag("o_wb_stb", wb_stb, 1'b0);
    check_flag("o_done_valid", done_valid, 1'b0);
    check_flag("o_disp_ready", disp_ready, 1'b1);
    end_test("reset state", errs);

    errs = n_errors;
    for (int i = 0; i < N_WORD; i++) begin
      addr = $random(seed) & 16'h03fc;
      send_op(OP_SW, addr, $random(seed));
      send_op(OP_LW, addr, '0);
    end
    wait_idle();
    end_test("word store then load", errs);

    errs = n_errors;
    base = $random(seed) & 16'h03fc;
    for (int l = 0; l < 4; l++) begin
      send_op(OP_SB, base | l, $random(seed));
    end
    send_op(OP_LW, base, '0);
    for (int l = 0; l < 4; l++) begin
      send_op(OP_LBU, base | l, '0);
    end
    wait_idle();
    end_test("byte lanes", errs);

    errs = n_errors;
    starts_before = bus_starts;
    for (int i = 0; i < N_MISALIGN; i++) begin
      addr       = ($random(seed) & 16'h03fc) | (1 + rand_below(3));
      mis_idx[i] = addr[9:2];
      send_op((i % 2 == 0) ? OP_SW : OP_LW, addr, $random(seed));
    end
    wait_idle();
    if (bus_starts != starts_before) begin
      n_errors++;
      $display("a Wishbone cycle was started for a misaligned word access");
    end
    for (int i = 0; i < N_MISALIGN; i++) begin
      check_data($sformatf("memory word 0x%02h", mis_idx[i]), mem[mis_idx[i]],
                 ref_mem[mis_idx[i]]);
    end
    end_test("misaligned words", errs);

    // Slow acks keep the bus busy so later operations go through replay
    errs     = n_errors;
    slow_ack = 1'b1;
    for (int i = 0; i < N_STRESS; i++) begin
      op   = lsu_op_e'(rand_below(4));
      addr = $random(seed) & 16'h03ff;
      if (((op == OP_LW) || (op == OP_SW)) && (rand_below(8) != 0)) begin
        addr[1:0] = 2'b00;
      end
      send_op(op, addr, $random(seed));
    end
    wait_idle();
    slow_ack = 1'b0;
    if (n_done != n_sent) begin
      n_errors++;
      $display("%0d done reports seen for %0d accepted operations", n_done, n_sent);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_data($sformatf("memory word 0x%02h", i), mem[i], ref_mem[i]);
    end
    end_test("random stress", errs);

    $display("%0d checks, %0d errors, %0d operations, %0d done reports, %0d cycles",
             n_checks, n_errors, n_sent, n_done, cycles);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/lsu_pkg.sv
rtl/lsu_issue_queue.sv
rtl/lsu_replay_queue.sv
rtl/lsu_pipe.sv
rtl/lsu_top.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_issue_queue.sv
      - rtl/lsu_replay_queue.sv
      - rtl/lsu_pipe.sv
      - rtl/lsu_top.sv
  - target: simulation
    files:
      - verification/lsu_tb.sv
